// File: mc_pod_row.f
+incdir+common
common/mc_noc_pkg.sv
common/mc_packet_pkg.sv
hdl/mc_link_fifo.sv
hdl/mc_router.sv
tile/mc_mem_endpoint.sv
tile/mc_tile.sv
pod/mc_pod.sv
pod/mc_pod_row.sv
sim/mc_row_model.sv
sim/tb_mc_pod_row.sv

// File: Makefile
# Verilator build and run of the pod row testbench
VERILATOR ?= verilator
TOP       ?= tb_mc_pod_row
FILELIST  ?= mc_pod_row.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: sim/tb_mc_pod_row.sv
/* directed and random traffic through the pod row, matched by tag in
   mc_row_model; a tag is reused only after its earlier request completed */
`include "mc_consts.svh"

module tb_mc_pod_row;
  timeunit 1ns;
  timeprecision 100ps;

  import mc_noc_pkg::*;
  import mc_packet_pkg::*;

  localparam int NT = `MC_NUM_PODS * `MC_TILES_PER_POD;

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      req_valid_i;
  logic                      req_ready_o;
  mc_req_pkt_t               req_pkt_i;
  logic                      resp_valid_o;
  logic                      resp_ready_i;
  mc_resp_pkt_t              resp_pkt_o;
  logic                      req_east_valid_o;
  logic                      req_east_ready_i;
  mc_req_pkt_t               req_east_pkt_o;
  logic [(1<<`MC_TAG_W)-1:0] busy;
  int                        value_errs;
  int                        other_errs;
  int                        tb_errs;
  int                        test_id;
  int                        issued;
  int                        cycles;
  int                        seed = 30004;
  int                        src_cnt [1<<`MC_X_W];
  int                        blocked_cnt;
  int                        blocked_before;
  int                        cnt_west;
  int                        cnt_east;
  tag_t                      next_tag;
  logic                      hold_resp;
  logic                      stall_resp;
  logic [31:0]               rv_resp;
  logic [31:0]               rv_east;
  logic [31:0]               rv_main;

  mc_pod_row i_dut (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_pkt_i(req_pkt_i),
    .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i), .resp_pkt_o(resp_pkt_o),
    .req_east_valid_o(req_east_valid_o), .req_east_ready_i(req_east_ready_i),
    .req_east_pkt_o(req_east_pkt_o)
  );

  mc_row_model model (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .test_id_i(test_id),
    .req_valid_i(req_valid_i), .req_ready_i(req_ready_o), .req_pkt_i(req_pkt_i),
    .resp_valid_i(resp_valid_o), .resp_ready_i(resp_ready_i), .resp_pkt_i(resp_pkt_o),
    .east_valid_i(req_east_valid_o), .east_ready_i(req_east_ready_i),
    .east_pkt_i(req_east_pkt_o),
    .busy_o(busy), .value_errs_o(value_errs), .other_errs_o(other_errs)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // each edge ready drops about 30% of cycles
  // hold_resp is sampled with the draw on the falling edge
  initial begin
    resp_ready_i     = 1'b0;
    req_east_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      rv_resp    = $random(seed);
      rv_east    = $random(seed);
      stall_resp = hold_resp;
      @(posedge clk_i);
      #1;
      resp_ready_i     = !stall_resp && (rv_resp % 10 >= 3);
      req_east_ready_i = (rv_east % 10 >= 3);
    end
  end

  // responses per source tile, and cycles the west edge pushed back
  initial begin
    foreach (src_cnt[i]) src_cnt[i] = 0;
    blocked_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (arst_n_i && resp_valid_o && resp_ready_i) src_cnt[resp_pkt_o.src_x]++;
      if (arst_n_i && req_valid_i && !req_ready_o) blocked_cnt++;
    end
  end

  function automatic void report_counts();
    $display("errors: value %0d, other %0d, testbench %0d", value_errs, other_errs, tb_errs);
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // called and returns 1 ns after a rising edge
  task automatic send_req(input mc_op_e op, input x_cord_t dst,
                          input logic [`MC_ADDR_W-1:0] addr,
                          input logic [`MC_DATA_W-1:0] data);
    mc_req_pkt_t pkt;
    logic        taken;
    pkt.op    = op;
    pkt.dst_x = dst;
    pkt.tag   = next_tag;
    pkt.addr  = addr;
    pkt.data  = data;
    next_tag  = tag_t'(next_tag + 1);
    while (busy[pkt.tag]) begin
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b1;
    req_pkt_i   = pkt;
    issued++;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = req_ready_o;
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic random_req(input x_cord_t dst);
    logic [31:0] rv;
    rv = rand_word();
    send_req(rv[0] ? STORE : LOAD, dst, rv[`MC_ADDR_W:1], rand_word());
  endtask

  task automatic drain();
    while (busy != '0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles <= 40 * issued + 500) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d requests issued, traffic did not drain",
             cycles, issued);
    report_counts();
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_pkt_i   = '0;
    hold_resp   = 1'b0;
    test_id     = 0;
    next_tag    = '0;
    tb_errs     = 0;
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #1;

    // quiet outputs, then every tile reads back zero
    test_id = 1;
    if (resp_valid_o !== 1'b0 || req_east_valid_o !== 1'b0) begin
      tb_errs++;
      $display("a valid output of the row was high right after reset");
    end
    for (int t = 0; t < NT; t++) begin
      rv_main = rand_word();
      send_req(LOAD, x_cord_t'(t), rv_main[`MC_ADDR_W-1:0], '0);
    end
    drain();

    test_id = 2;
    for (int t = 0; t < NT; t++) begin
      rv_main = rand_word();
      send_req(STORE, x_cord_t'(t), rv_main[`MC_ADDR_W-1:0], rand_word());
      send_req(LOAD, x_cord_t'(t), rv_main[`MC_ADDR_W-1:0], '0);
    end
    drain();

    // coordinates past the last tile
    test_id = 3;
    for (int k = 0; k < 6; k++) begin
      rv_main = rand_word();
      send_req((k % 2 == 0) ? STORE : LOAD, x_cord_t'(NT + k % ((1 << `MC_X_W) - NT)),
               rv_main[`MC_ADDR_W-1:0], rand_word());
    end
    drain();

    test_id = 4;
    repeat (200) random_req(x_cord_t'(rand_word() % (NT + 2)));
    drain();

    // stall the west response edge until the request edge pushes back
    test_id = 5;
    hold_resp = 1'b1;
    blocked_before = blocked_cnt;
    fork
      begin
        repeat (80) @(posedge clk_i);
        hold_resp = 1'b0;
      end
      begin
        for (int k = 0; k < 8; k++) random_req('0);
      end
    join
    drain();
    if (blocked_cnt == blocked_before) begin
      tb_errs++;
      $display("req_ready_o never fell while responses were stalled");
    end

    // both ends of the row at once through the reverse merge
    test_id = 6;
    cnt_west = src_cnt[0];
    cnt_east = src_cnt[NT-1];
    for (int k = 0; k < 24; k++) random_req(x_cord_t'((k % 2) * (NT - 1)));
    drain();
    if (src_cnt[0] - cnt_west != 12 || src_cnt[NT-1] - cnt_east != 12) begin
      tb_errs++;
      $display("[ERROR] merge_fairness expected 12 and 12 responses actual %0d and %0d",
               src_cnt[0] - cnt_west, src_cnt[NT-1] - cnt_east);
    end

    test_id = 0;
    report_counts();
    if (value_errs + other_errs + tb_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim/mc_row_model.sv
/* scoreboard for the pod row; samples on the falling edge, so a transfer
   seen here completes on the next rising edge */
`include "mc_consts.svh"

module mc_row_model (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  int                          test_id_i,
  input  logic                        req_valid_i,
  input  logic                        req_ready_i,
  input  mc_packet_pkg::mc_req_pkt_t  req_pkt_i,
  input  logic                        resp_valid_i,
  input  logic                        resp_ready_i,
  input  mc_packet_pkg::mc_resp_pkt_t resp_pkt_i,
  input  logic                        east_valid_i,
  input  logic                        east_ready_i,
  input  mc_packet_pkg::mc_req_pkt_t  east_pkt_i,
  output logic [(1<<`MC_TAG_W)-1:0]   busy_o,
  output int                          value_errs_o,
  output int                          other_errs_o
);
  timeunit 1ns;
  timeprecision 100ps;

  import mc_packet_pkg::*;

  localparam int NT = `MC_NUM_PODS * `MC_TILES_PER_POD;

  // one word memory per coordinate, only 0..NT-1 are used
  logic [`MC_DATA_W-1:0]     mem [1<<`MC_X_W][`MC_MEM_WORDS];
  mc_resp_pkt_t              exp_resp [1<<`MC_TAG_W];
  logic [(1<<`MC_TAG_W)-1:0] to_east;
  mc_req_pkt_t               east_q [$];

  function automatic string test_label(input int id);
    case (id)
      1: return "reset_load";
      2: return "store_load";
      3: return "east_pass";
      4: return "random_mix";
      5: return "backpressure";
      6: return "merge_fairness";
      default: return "idle";
    endcase
  endfunction

  task automatic check_resp(input mc_resp_pkt_t exp_pkt, input mc_resp_pkt_t act_pkt);
    if (act_pkt !== exp_pkt) begin
      value_errs_o++;
      $display("[ERROR] %s expected %h actual %h", test_label(test_id_i), exp_pkt, act_pkt);
    end
  endtask

  task automatic check_east(input mc_req_pkt_t exp_pkt, input mc_req_pkt_t act_pkt);
    if (act_pkt !== exp_pkt) begin
      value_errs_o++;
      $display("[ERROR] %s expected %h actual %h", test_label(test_id_i), exp_pkt, act_pkt);
    end
  endtask

  // memory is updated in acceptance order, same-tile order holds in the row
  task automatic apply_req(input mc_req_pkt_t pkt);
    mc_resp_pkt_t rsp;
    if (busy_o[pkt.tag]) begin
      other_errs_o++;
      $display("request accepted with tag %0d while that tag was still in flight", pkt.tag);
    end
    busy_o[pkt.tag] = 1'b1;
    if (int'(pkt.dst_x) < NT) begin
      rsp.src_x = pkt.dst_x;
      rsp.tag   = pkt.tag;
      rsp.op    = pkt.op;
      rsp.data  = (pkt.op == STORE) ? pkt.data : mem[pkt.dst_x][pkt.addr];
      if (pkt.op == STORE) mem[pkt.dst_x][pkt.addr] = pkt.data;
      exp_resp[pkt.tag] = rsp;
      to_east[pkt.tag]  = 1'b0;
    end else begin
      east_q.push_back(pkt);
      to_east[pkt.tag] = 1'b1;
    end
  endtask

  task automatic take_resp(input mc_resp_pkt_t pkt);
    if (!busy_o[pkt.tag] || to_east[pkt.tag]) begin
      other_errs_o++;
      $display("response with unknown tag %0d from tile %0d in test %s",
               pkt.tag, pkt.src_x, test_label(test_id_i));
    end else begin
      check_resp(exp_resp[pkt.tag], pkt);
      busy_o[pkt.tag] = 1'b0;
    end
  endtask

  task automatic take_east(input mc_req_pkt_t pkt);
    mc_req_pkt_t exp_pkt;
    if (east_q.size() == 0) begin
      other_errs_o++;
      $display("east edge packet with tag %0d arrived when none was expected", pkt.tag);
    end else begin
      exp_pkt = east_q.pop_front();
      check_east(exp_pkt, pkt);
      busy_o[exp_pkt.tag] = 1'b0;
    end
  endtask

  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      mem          = '{default: '0};
      exp_resp     = '{default: '0};
      to_east      = '0;
      busy_o       = '0;
      value_errs_o = 0;
      other_errs_o = 0;
      east_q.delete();
    end else begin
      if (resp_valid_i && resp_ready_i) take_resp(resp_pkt_i);
      if (east_valid_i && east_ready_i) take_east(east_pkt_i);
      if (req_valid_i && req_ready_i) apply_req(req_pkt_i);
    end
  end

endmodule

// File: pod/mc_pod_row.sv
/* requests enter west, responses leave west; requests past the last tile
   leave east and get no response; the east reverse input is tied off */
`include "mc_consts.svh"

module mc_pod_row (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  mc_packet_pkg::mc_req_pkt_t  req_pkt_i,
  output logic                        resp_valid_o,
  input  logic                        resp_ready_i,
  output mc_packet_pkg::mc_resp_pkt_t resp_pkt_o,
  output logic                        req_east_valid_o,
  input  logic                        req_east_ready_i,
  output mc_packet_pkg::mc_req_pkt_t  req_east_pkt_o
);

  import mc_packet_pkg::*;

  localparam int P = `MC_NUM_PODS;

  logic         fwd_valid [0:P];
  logic         fwd_ready [0:P];
  mc_req_pkt_t  fwd_pkt   [0:P];
  logic         rev_valid [0:P];
  logic         rev_ready [0:P];
  mc_resp_pkt_t rev_pkt   [0:P];

  // west edge
  assign fwd_valid[0] = req_valid_i;
  assign fwd_pkt[0]   = req_pkt_i;
  assign req_ready_o  = fwd_ready[0];
  assign resp_valid_o = rev_valid[0];
  assign resp_pkt_o   = rev_pkt[0];
  assign rev_ready[0] = resp_ready_i;

  // east edge, reverse input tied off
  assign req_east_valid_o = fwd_valid[P];
  assign req_east_pkt_o   = fwd_pkt[P];
  assign fwd_ready[P]     = req_east_ready_i;
  assign rev_valid[P]     = 1'b0;
  assign rev_pkt[P]       = '0;

  for (genvar x = 0; x < P; x++) begin : g_pod
    mc_pod #(.pod_x_p(x)) pod (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .fwd_in_valid_i(fwd_valid[x]), .fwd_in_ready_o(fwd_ready[x]),
      .fwd_in_pkt_i(fwd_pkt[x]),
      .fwd_out_valid_o(fwd_valid[x+1]), .fwd_out_ready_i(fwd_ready[x+1]),
      .fwd_out_pkt_o(fwd_pkt[x+1]),
      .rev_in_valid_i(rev_valid[x+1]), .rev_in_ready_o(rev_ready[x+1]),
      .rev_in_pkt_i(rev_pkt[x+1]),
      .rev_out_valid_o(rev_valid[x]), .rev_out_ready_i(rev_ready[x]),
      .rev_out_pkt_o(rev_pkt[x])
    );
  end

endmodule

// File: pod/mc_pod.sv
/* tiles get consecutive X coordinates starting at pod_x_p*MC_TILES_PER_POD;
   index 0 is the west end */
`include "mc_consts.svh"

module mc_pod #(
  parameter int pod_x_p = 0
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        fwd_in_valid_i,
  output logic                        fwd_in_ready_o,
  input  mc_packet_pkg::mc_req_pkt_t  fwd_in_pkt_i,
  output logic                        fwd_out_valid_o,
  input  logic                        fwd_out_ready_i,
  output mc_packet_pkg::mc_req_pkt_t  fwd_out_pkt_o,
  input  logic                        rev_in_valid_i,
  output logic                        rev_in_ready_o,
  input  mc_packet_pkg::mc_resp_pkt_t rev_in_pkt_i,
  output logic                        rev_out_valid_o,
  input  logic                        rev_out_ready_i,
  output mc_packet_pkg::mc_resp_pkt_t rev_out_pkt_o
);

  import mc_noc_pkg::*;
  import mc_packet_pkg::*;

  localparam int N = `MC_TILES_PER_POD;

  // link k sits west of tile k
  logic         fwd_valid [0:N];
  logic         fwd_ready [0:N];
  mc_req_pkt_t  fwd_pkt   [0:N];
  logic         rev_valid [0:N];
  logic         rev_ready [0:N];
  mc_resp_pkt_t rev_pkt   [0:N];

  assign fwd_valid[0]    = fwd_in_valid_i;
  assign fwd_pkt[0]      = fwd_in_pkt_i;
  assign fwd_in_ready_o  = fwd_ready[0];
  assign fwd_out_valid_o = fwd_valid[N];
  assign fwd_out_pkt_o   = fwd_pkt[N];
  assign fwd_ready[N]    = fwd_out_ready_i;

  assign rev_valid[N]    = rev_in_valid_i;
  assign rev_pkt[N]      = rev_in_pkt_i;
  assign rev_in_ready_o  = rev_ready[N];
  assign rev_out_valid_o = rev_valid[0];
  assign rev_out_pkt_o   = rev_pkt[0];
  assign rev_ready[0]    = rev_out_ready_i;

  for (genvar i = 0; i < N; i++) begin : g_tile
    mc_tile #(.x_cord_p(x_cord_t'(pod_x_p * N + i))) tile (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .fwd_in_valid_i(fwd_valid[i]), .fwd_in_ready_o(fwd_ready[i]),
      .fwd_in_pkt_i(fwd_pkt[i]),
      .fwd_out_valid_o(fwd_valid[i+1]), .fwd_out_ready_i(fwd_ready[i+1]),
      .fwd_out_pkt_o(fwd_pkt[i+1]),
      .rev_in_valid_i(rev_valid[i+1]), .rev_in_ready_o(rev_ready[i+1]),
      .rev_in_pkt_i(rev_pkt[i+1]),
      .rev_out_valid_o(rev_valid[i]), .rev_out_ready_i(rev_ready[i]),
      .rev_out_pkt_o(rev_pkt[i])
    );
  end

endmodule

// File: tile/mc_tile.sv
/* both incoming links are registered, so no combinational path crosses
   a tile boundary */
module mc_tile #(
  parameter mc_noc_pkg::x_cord_t x_cord_p = '0
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        fwd_in_valid_i,
  output logic                        fwd_in_ready_o,
  input  mc_packet_pkg::mc_req_pkt_t  fwd_in_pkt_i,
  output logic                        fwd_out_valid_o,
  input  logic                        fwd_out_ready_i,
  output mc_packet_pkg::mc_req_pkt_t  fwd_out_pkt_o,
  input  logic                        rev_in_valid_i,
  output logic                        rev_in_ready_o,
  input  mc_packet_pkg::mc_resp_pkt_t rev_in_pkt_i,
  output logic                        rev_out_valid_o,
  input  logic                        rev_out_ready_i,
  output mc_packet_pkg::mc_resp_pkt_t rev_out_pkt_o
);

  import mc_packet_pkg::*;

  logic         fwd_valid, fwd_ready;
  mc_req_pkt_t  fwd_pkt;
  logic         thru_valid, thru_ready;
  mc_resp_pkt_t thru_pkt;
  logic         ej_valid, ej_ready;
  mc_req_pkt_t  ej_pkt;
  logic         loc_valid, loc_ready;
  mc_resp_pkt_t loc_pkt;

  mc_link_fifo #(.pkt_t(mc_req_pkt_t)) fwd_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .in_valid_i(fwd_in_valid_i), .in_ready_o(fwd_in_ready_o), .in_pkt_i(fwd_in_pkt_i),
    .out_valid_o(fwd_valid), .out_ready_i(fwd_ready), .out_pkt_o(fwd_pkt)
  );

  mc_link_fifo #(.pkt_t(mc_resp_pkt_t)) rev_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .in_valid_i(rev_in_valid_i), .in_ready_o(rev_in_ready_o), .in_pkt_i(rev_in_pkt_i),
    .out_valid_o(thru_valid), .out_ready_i(thru_ready), .out_pkt_o(thru_pkt)
  );

  mc_router #(.x_cord_p(x_cord_p)) router (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .fwd_valid_i(fwd_valid), .fwd_ready_o(fwd_ready), .fwd_pkt_i(fwd_pkt),
    .east_valid_o(fwd_out_valid_o), .east_ready_i(fwd_out_ready_i),
    .east_pkt_o(fwd_out_pkt_o),
    .ej_valid_o(ej_valid), .ej_ready_i(ej_ready), .ej_pkt_o(ej_pkt),
    .loc_valid_i(loc_valid), .loc_ready_o(loc_ready), .loc_pkt_i(loc_pkt),
    .thru_valid_i(thru_valid), .thru_ready_o(thru_ready), .thru_pkt_i(thru_pkt),
    .west_valid_o(rev_out_valid_o), .west_ready_i(rev_out_ready_i),
    .west_pkt_o(rev_out_pkt_o)
  );

  mc_mem_endpoint #(.x_cord_p(x_cord_p)) endpoint (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .req_valid_i(ej_valid), .req_ready_o(ej_ready), .req_pkt_i(ej_pkt),
    .resp_valid_o(loc_valid), .resp_ready_i(loc_ready), .resp_pkt_o(loc_pkt)
  );

endmodule

// File: tile/mc_mem_endpoint.sv
/* one request at a time; no new request is taken while a response is
   held, so throughput is at most one request every two cycles */
`include "mc_consts.svh"

module mc_mem_endpoint #(
  parameter mc_noc_pkg::x_cord_t x_cord_p = '0
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  mc_packet_pkg::mc_req_pkt_t  req_pkt_i,
  output logic                        resp_valid_o,
  input  logic                        resp_ready_i,
  output mc_packet_pkg::mc_resp_pkt_t resp_pkt_o
);

  import mc_packet_pkg::*;

  logic [`MC_DATA_W-1:0] mem_q [`MC_MEM_WORDS];
  logic                  resp_valid_q;
  mc_resp_pkt_t          resp_pkt_q;
  logic                  req_fire;

  assign req_ready_o  = ~resp_valid_q;
  assign req_fire     = req_valid_i & req_ready_o;
  assign resp_valid_o = resp_valid_q;
  assign resp_pkt_o   = resp_pkt_q;

  // word memory starts out all zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `MC_MEM_WORDS; i++) mem_q[i] <= '0;
    end else if (req_fire && req_pkt_i.op == STORE) begin
      mem_q[req_pkt_i.addr] <= req_pkt_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_pkt_q.src_x <= x_cord_p;
      resp_pkt_q.tag   <= req_pkt_i.tag;
      resp_pkt_q.op    <= req_pkt_i.op;
      // store echoes the written word
      resp_pkt_q.data  <= (req_pkt_i.op == STORE) ? req_pkt_i.data : mem_q[req_pkt_i.addr];
    end
  end

endmodule

// File: hdl/mc_router.sv
/* combinational between the tile FIFOs; an ejecting packet that is not
   taken blocks the forward path, there is no bypass */
module mc_router #(
  parameter mc_noc_pkg::x_cord_t x_cord_p = '0
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        fwd_valid_i,
  output logic                        fwd_ready_o,
  input  mc_packet_pkg::mc_req_pkt_t  fwd_pkt_i,
  output logic                        east_valid_o,
  input  logic                        east_ready_i,
  output mc_packet_pkg::mc_req_pkt_t  east_pkt_o,
  output logic                        ej_valid_o,
  input  logic                        ej_ready_i,
  output mc_packet_pkg::mc_req_pkt_t  ej_pkt_o,
  input  logic                        loc_valid_i,
  output logic                        loc_ready_o,
  input  mc_packet_pkg::mc_resp_pkt_t loc_pkt_i,
  input  logic                        thru_valid_i,
  output logic                        thru_ready_o,
  input  mc_packet_pkg::mc_resp_pkt_t thru_pkt_i,
  output logic                        west_valid_o,
  input  logic                        west_ready_i,
  output mc_packet_pkg::mc_resp_pkt_t west_pkt_o
);

  import mc_noc_pkg::*;

  logic    eject;
  logic    pick_loc;
  logic    both_wait;
  rr_dir_e rr_q;
  logic    hold_q;
  rr_dir_e hold_dir_q;

  // forward side: eject on matching X, else pass east
  assign eject        = (fwd_pkt_i.dst_x == x_cord_p);
  assign ej_valid_o   = fwd_valid_i & eject;
  assign east_valid_o = fwd_valid_i & ~eject;
  assign ej_pkt_o     = fwd_pkt_i;
  assign east_pkt_o   = fwd_pkt_i;
  assign fwd_ready_o  = eject ? ej_ready_i : east_ready_i;

  // reverse side: keep a stalled choice so west_pkt_o stays stable
  assign both_wait = loc_valid_i & thru_valid_i;

  always_comb begin
    if (hold_q) begin
      pick_loc = (hold_dir_q == LOCAL);
    end else begin
      pick_loc = loc_valid_i & (~thru_valid_i | (rr_q == LOCAL));
    end
  end

  assign west_valid_o = loc_valid_i | thru_valid_i;
  assign west_pkt_o   = pick_loc ? loc_pkt_i : thru_pkt_i;
  assign loc_ready_o  = pick_loc & west_ready_i;
  assign thru_ready_o = ~pick_loc & west_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= THRU;
      hold_q     <= 1'b0;
      hold_dir_q <= THRU;
    end else begin
      hold_q     <= west_valid_o & ~west_ready_i;
      hold_dir_q <= pick_loc ? LOCAL : THRU;
      // loser of a contested grant goes first next time
      if (both_wait && west_ready_i) rr_q <= pick_loc ? THRU : LOCAL;
    end
  end

endmodule

// File: hdl/mc_link_fifo.sv
/* two-entry ready/valid FIFO; in_ready_o depends only on state, so
   no combinational path runs from out_ready_i back to the input */
module mc_link_fifo #(
  parameter type pkt_t = logic [7:0]
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  pkt_t in_pkt_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output pkt_t out_pkt_o
);

  pkt_t       mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       in_fire;
  logic       out_fire;

  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign out_pkt_o   = mem_q[rd_ptr_q];

  assign in_fire  = in_valid_i & in_ready_o;
  assign out_fire = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (in_fire) wr_ptr_q <= ~wr_ptr_q;
      if (out_fire) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + 2'(in_fire) - 2'(out_fire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) mem_q[wr_ptr_q] <= in_pkt_i;
  end

endmodule

// File: common/mc_packet_pkg.sv
/* request and response packet formats; one word per packet, no bursts */
`include "mc_consts.svh"

package mc_packet_pkg;
  import mc_noc_pkg::*;

  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } mc_op_e;

  // forward network, west to east
  typedef struct packed {
    mc_op_e                 op;
    x_cord_t                dst_x;
    tag_t                   tag;
    logic [`MC_ADDR_W-1:0]  addr;
    logic [`MC_DATA_W-1:0]  data;
  } mc_req_pkt_t;

  // reverse network, east to west
  // data is the stored word for STORE, the read word for LOAD
  typedef struct packed {
    x_cord_t                src_x;
    tag_t                   tag;
    mc_op_e                 op;
    logic [`MC_DATA_W-1:0]  data;
  } mc_resp_pkt_t;

endpackage

// File: common/mc_noc_pkg.sv
/* link-level types shared by routers and the row; X only, no Y dimension */
`include "mc_consts.svh"

package mc_noc_pkg;

  // tile coordinate along the row
  typedef logic [`MC_X_W-1:0] x_cord_t;

  // request identifier, echoed in the response
  typedef logic [`MC_TAG_W-1:0] tag_t;

  // which reverse source gets priority next
  typedef enum logic {
    LOCAL = 1'b0,
    THRU  = 1'b1
  } rr_dir_e;

endpackage

// File: common/mc_consts.svh
/* row geometry and field widths; MC_X_W must cover every tile plus
   the out-of-range values that leave at the east edge */
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

`define MC_NUM_PODS      2
`define MC_TILES_PER_POD 2

// coordinate, address, data and tag widths
`define MC_X_W    3
`define MC_ADDR_W 4
`define MC_DATA_W 32
`define MC_TAG_W  4

`define MC_MEM_WORDS (1 << `MC_ADDR_W)

`endif
